//--- hw/board_pkg.sv
`default_nettype none

package board_pkg;

  // color depth of the design side, the header only gets the top 4 bits
  localparam int color_depth = 6;
  localparam int color_max = 63;

  localparam int num_leds = 5;
  localparam int num_btns = 3;

  // 640x480 horizontal timing, in pixels
  localparam int h_active = 640;
  localparam int h_sync_start = 656;
  localparam int h_sync_end = 752;
  localparam int h_total = 800;

  // vertical timing, in lines
  localparam int v_active = 480;
  localparam int v_sync_start = 490;
  localparam int v_sync_end = 492;
  localparam int v_total = 525;

  localparam int coord_width = 10;
  localparam int bar_width = h_active / 8;  // eight color bars

  localparam int debounce_cycles = 1024;
  localparam int debounce_width = $clog2(debounce_cycles);

  localparam int reset_stretch_cycles = 32;
  localparam int stretch_width = $clog2(reset_stretch_cycles + 1);

  localparam int pattern_width = 2;
  localparam logic [pattern_width-1:0] pattern_bars = 2'd0;
  localparam logic [pattern_width-1:0] pattern_checker = 2'd1;
  localparam logic [pattern_width-1:0] pattern_gradient = 2'd2;

endpackage

`default_nettype wire

//--- hw/video_if.sv
`timescale 1ns/1ps
`default_nettype none

interface video_if;
  import board_pkg::*;

  logic [coord_width-1:0] x;
  logic [coord_width-1:0] y;
  logic active;
  logic hs;  // active low
  logic vs;  // active low
  logic frame_start;  // one cycle at x=0, y=0

  modport source (
    output x, y, active, hs, vs, frame_start
  );

  modport sink (
    input x, y, active, hs, vs, frame_start
  );

endinterface

`default_nettype wire

//--- hw/reset_stretcher.sv
`timescale 1ns/1ps
`default_nettype none

module reset_stretcher (
  input  logic design_clk,
  input  logic rst,
  output logic sys_rst
);
  import board_pkg::*;

  logic [stretch_width-1:0] stretch_cnt;
  logic stretch_q;

  always_ff @(posedge design_clk) begin
    if (rst) begin
      stretch_cnt <= stretch_width'(reset_stretch_cycles);
      stretch_q <= 1'b1;
    end else begin
      if (stretch_cnt != '0) begin
        stretch_cnt <= stretch_cnt - 1'b1;
      end
      stretch_q <= (stretch_cnt != '0);  // drops one edge after count hits zero
    end
  end

  // external reset passes straight through, the counter only extends it
  assign sys_rst = rst | stretch_q;

endmodule

`default_nettype wire

//--- hw/button_debouncer.sv
`timescale 1ns/1ps
`default_nettype none

module button_debouncer (
  input  logic design_clk,
  input  logic sys_rst,
  input  logic [board_pkg::num_btns-1:0] btns,
  output logic [board_pkg::num_btns-1:0] btn_level
);
  import board_pkg::*;

  logic [num_btns-1:0] sync_q1;
  logic [num_btns-1:0] sync_q2;
  logic [debounce_width-1:0] stable_cnt [num_btns];

  // two flop synchronizer, pins are asynchronous to design_clk
  always_ff @(posedge design_clk) begin
    if (sys_rst) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= btns;
      sync_q2 <= sync_q1;
    end
  end

  always_ff @(posedge design_clk) begin
    if (sys_rst) begin
      btn_level <= '0;
      for (int i = 0; i < num_btns; i++) begin
        stable_cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < num_btns; i++) begin
        if (sync_q2[i] == btn_level[i]) begin
          stable_cnt[i] <= '0;  // no pending change, or a bounce back
        end else if (stable_cnt[i] == debounce_width'(debounce_cycles - 1)) begin
          stable_cnt[i] <= '0;
          btn_level[i] <= sync_q2[i];  // stable long enough
        end else begin
          stable_cnt[i] <= stable_cnt[i] + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/video_timing.sv
`timescale 1ns/1ps
`default_nettype none

module video_timing (
  input  logic design_clk,
  input  logic sys_rst,
  video_if.source vid
);
  import board_pkg::*;

  logic [coord_width-1:0] h_cnt;
  logic [coord_width-1:0] v_cnt;
  logic h_last;
  logic v_last;
  logic h_visible;
  logic v_visible;
  logic running;

  assign h_last = (h_cnt == coord_width'(h_total - 1));
  assign v_last = (v_cnt == coord_width'(v_total - 1));

  always_ff @(posedge design_clk) begin
    if (sys_rst) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (h_last) begin
      h_cnt <= '0;
      if (v_last) begin
        v_cnt <= '0;
      end else begin
        v_cnt <= v_cnt + 1'b1;
      end
    end else begin
      h_cnt <= h_cnt + 1'b1;
    end
  end

  // counters sit at 0,0 in reset, which already gives idle sync levels
  assign running = ~sys_rst;
  assign h_visible = (h_cnt < coord_width'(h_active));
  assign v_visible = (v_cnt < coord_width'(v_active));

  assign vid.x = h_cnt;
  assign vid.y = v_cnt;

  assign vid.hs = ~((h_cnt >= coord_width'(h_sync_start)) &&
                    (h_cnt < coord_width'(h_sync_end)));
  assign vid.vs = ~((v_cnt >= coord_width'(v_sync_start)) &&
                    (v_cnt < coord_width'(v_sync_end)));

  assign vid.active = running & h_visible & v_visible;

  // first cycle after reset is already pixel 0,0 of frame 0
  assign vid.frame_start = running & (h_cnt == '0) & (v_cnt == '0);

endmodule

`default_nettype wire

//--- hw/pixel_shader.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_shader (
  input  logic design_clk,
  input  logic sys_rst,
  video_if.sink vid,
  input  logic [board_pkg::num_btns-1:0] btn_level,
  output logic [board_pkg::color_depth-1:0] r,
  output logic [board_pkg::color_depth-1:0] g,
  output logic [board_pkg::color_depth-1:0] b,
  output logic hs,
  output logic vs,
  output logic [board_pkg::num_leds-1:0] leds
);
  import board_pkg::*;

  logic [pattern_width-1:0] pattern;
  logic [pattern_width-1:0] sel_pattern;
  logic [2:0] pattern_onehot;
  logic [coord_width-1:0] bar_idx;
  logic checker_on;
  logic [color_depth-1:0] r_next;
  logic [color_depth-1:0] g_next;
  logic [color_depth-1:0] b_next;

  // new pattern applies from pixel 0,0 of the frame onwards
  always_comb begin
    sel_pattern = pattern;
    if (vid.frame_start) begin
      if (btn_level[0]) begin
        sel_pattern = pattern_bars;
      end else if (btn_level[1]) begin
        sel_pattern = pattern_checker;
      end else if (btn_level[2]) begin
        sel_pattern = pattern_gradient;
      end
    end
  end

  always_comb begin
    case (sel_pattern)
      pattern_bars:     pattern_onehot = 3'b001;
      pattern_checker:  pattern_onehot = 3'b010;
      pattern_gradient: pattern_onehot = 3'b100;
      default:          pattern_onehot = 3'b000;
    endcase
  end

  assign bar_idx = vid.x / coord_width'(bar_width);
  assign checker_on = vid.x[5] ^ vid.y[5];  // 32 pixel squares

  always_comb begin
    r_next = '0;
    g_next = '0;
    b_next = '0;
    if (vid.active) begin
      case (sel_pattern)
        pattern_bars: begin
          r_next = bar_idx[2] ? color_depth'(color_max) : '0;
          g_next = bar_idx[1] ? color_depth'(color_max) : '0;
          b_next = bar_idx[0] ? color_depth'(color_max) : '0;
        end
        pattern_checker: begin
          r_next = checker_on ? color_depth'(color_max) : '0;
          g_next = checker_on ? color_depth'(color_max) : '0;
          b_next = checker_on ? color_depth'(color_max) : '0;
        end
        pattern_gradient: begin
          r_next = vid.x[4 +: color_depth];  // x / 16
          g_next = vid.y[3 +: color_depth];  // y / 8
        end
        default: begin
          r_next = '0;
        end
      endcase
    end
  end

  always_ff @(posedge design_clk) begin
    if (sys_rst) begin
      r <= '0;
      g <= '0;
      b <= '0;
      hs <= 1'b1;
      vs <= 1'b1;
      pattern <= pattern_bars;
      leds <= '0;
    end else begin
      r <= r_next;
      g <= g_next;
      b <= b_next;
      hs <= vid.hs;  // keep sync aligned with color
      vs <= vid.vs;
      pattern <= sel_pattern;
      leds[2:0] <= pattern_onehot;
      leds[3] <= leds[3] ^ vid.frame_start;  // frame heartbeat
      leds[4] <= vid.active;
    end
  end

endmodule

`default_nettype wire

//--- hw/board_top.sv
`timescale 1ns/1ps
`default_nettype none

module board_top (
  input  logic design_clk,
  input  logic rst,
  input  logic btn1,
  input  logic btn2,
  input  logic btn3,
  output logic led1,
  output logic led2,
  output logic led3,
  output logic led4,
  output logic led5,
  output logic [3:0] vga_r,
  output logic [3:0] vga_g,
  output logic [3:0] vga_b,
  output logic vga_hs,
  output logic vga_vs
);
  import board_pkg::*;

  logic sys_rst;
  logic [num_btns-1:0] btns;
  logic [num_btns-1:0] btn_level;
  logic [num_leds-1:0] leds;
  logic [color_depth-1:0] r;
  logic [color_depth-1:0] g;
  logic [color_depth-1:0] b;
  logic hs;
  logic vs;

  video_if vid ();

  assign btns = {btn3, btn2, btn1};

  reset_stretcher reset_stretcher_i (
    .design_clk (design_clk),
    .rst        (rst),
    .sys_rst    (sys_rst)
  );

  button_debouncer button_debouncer_i (
    .design_clk (design_clk),
    .sys_rst    (sys_rst),
    .btns       (btns),
    .btn_level  (btn_level)
  );

  video_timing video_timing_i (
    .design_clk (design_clk),
    .sys_rst    (sys_rst),
    .vid        (vid.source)
  );

  pixel_shader pixel_shader_i (
    .design_clk (design_clk),
    .sys_rst    (sys_rst),
    .vid        (vid.sink),
    .btn_level  (btn_level),
    .r          (r),
    .g          (g),
    .b          (b),
    .hs         (hs),
    .vs         (vs),
    .leds       (leds)
  );

  // led placement on the board is not in index order
  assign led4 = leds[0];
  assign led3 = leds[1];
  assign led5 = leds[2];
  assign led2 = leds[3];
  assign led1 = leds[4];

  // 12 pin header, upper bits of each channel
  assign vga_r = r[color_depth-1 -: 4];
  assign vga_g = g[color_depth-1 -: 4];
  assign vga_b = b[color_depth-1 -: 4];
  assign vga_hs = hs;
  assign vga_vs = vs;

endmodule

`default_nettype wire

//--- testbench/board_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

module board_top_tb;
  import board_pkg::*;

  localparam int clk_half = 20;
  localparam int reset_cycles = 10;
  localparam int frame_cycles = h_total * v_total;
  localparam int num_frames = 4;
  localparam int timeout_cycles = num_frames * 420000 + 100;
  localparam int release_edge = reset_cycles + reset_stretch_cycles + 1;  // last edge in reset
  localparam int end_edge = release_edge + num_frames * frame_cycles;
  localparam int settle_cycles = debounce_cycles + 100;
  localparam int first_hs_edge = reset_cycles + 1 + reset_stretch_cycles + 1 + h_sync_start;
  localparam int short_lead = 300;  // short press starts this far before a frame start

  logic design_clk;
  logic rst;
  logic btn1;
  logic btn2;
  logic btn3;
  logic led1;
  logic led2;
  logic led3;
  logic led4;
  logic led5;
  logic [3:0] vga_r;
  logic [3:0] vga_g;
  logic [3:0] vga_b;
  logic vga_hs;
  logic vga_vs;

  int cyc;
  int error_count;
  int first_hs_fall;
  logic prev_hs;
  logic [31:0] lfsr_state;
  logic [num_btns-1:0] settled_btns;  // levels the debouncer must show by now
  logic [pattern_width-1:0] exp_pattern;
  logic exp_frame_led;

  board_top dut_i (
    .design_clk (design_clk),
    .rst        (rst),
    .btn1       (btn1),
    .btn2       (btn2),
    .btn3       (btn3),
    .led1       (led1),
    .led2       (led2),
    .led3       (led3),
    .led4       (led4),
    .led5       (led5),
    .vga_r      (vga_r),
    .vga_g      (vga_g),
    .vga_b      (vga_b),
    .vga_hs     (vga_hs),
    .vga_vs     (vga_vs)
  );

  initial begin
    design_clk = 1'b0;
    forever #clk_half design_clk = ~design_clk;
  end

  always @(posedge design_clk) begin
    cyc <= cyc + 1;
    if (cyc >= timeout_cycles) begin
      $display("run did not finish within %0d cycles", timeout_cycles);
      $display("FAIL: see errors above");
      $fatal(1, "timeout");
    end
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] nxt;
    nxt = state >> 1;
    if (state[0]) begin
      nxt = nxt ^ 32'hB4BCD35C;
    end
    return nxt;
  endfunction

  task automatic take_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      val = (val << 1) | lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // lowest pressed button wins, none keeps the pattern
  function automatic logic [pattern_width-1:0] next_pattern(
    input logic [num_btns-1:0] lvl, input logic [pattern_width-1:0] cur);
    if (lvl[0]) return pattern_bars;
    if (lvl[1]) return pattern_checker;
    if (lvl[2]) return pattern_gradient;
    return cur;
  endfunction

  // {r, g, b, hs, vs} as seen on the header pins
  function automatic logic [13:0] expected_pins(input int x, input int y,
                                                input logic [pattern_width-1:0] pat);
    int r;
    int g;
    int b;
    int k;
    logic hs;
    logic vs;
    r = 0;
    g = 0;
    b = 0;
    hs = !(x >= h_sync_start && x < h_sync_end);
    vs = !(y >= v_sync_start && y < v_sync_end);
    if (x < h_active && y < v_active) begin
      case (pat)
        pattern_bars: begin
          k = x / 80;
          r = ((k >> 2) & 1) ? color_max : 0;
          g = ((k >> 1) & 1) ? color_max : 0;
          b = (k & 1) ? color_max : 0;
        end
        pattern_checker: begin
          if (((x >> 5) & 1) != ((y >> 5) & 1)) begin
            r = color_max;
            g = color_max;
            b = color_max;
          end
        end
        pattern_gradient: begin
          r = x / 16;
          g = y / 8;
        end
        default: r = 0;
      endcase
    end
    return {4'(r >> 2), 4'(g >> 2), 4'(b >> 2), hs, vs};
  endfunction

  task automatic check_value(input string name, input logic [15:0] actual,
                             input logic [15:0] expected);
    assert (actual === expected) else begin
      error_count++;
      $display("error at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
      $display("FAIL: see errors above");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic wait_until_edge(input int target);
    while (cyc < target) begin
      @(posedge design_clk);
      #1;
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) begin
      @(posedge design_clk);
      #1;
    end
  endtask

  task automatic drive_btns(input logic [num_btns-1:0] val);
    {btn3, btn2, btn1} = val;
  endtask

  task automatic press_with_bounce(input int btn);
    int on_len;
    int off_len;
    for (int i = 0; i < 3; i++) begin
      take_bits(8, on_len);
      take_bits(6, off_len);
      drive_btns(3'b1 << btn);
      wait_cycles(16 + on_len);  // well under debounce_cycles
      drive_btns('0);
      wait_cycles(16 + off_len);
    end
    drive_btns(3'b1 << btn);
  endtask

  always @(negedge design_clk) begin
    int p;
    int x;
    int y;
    logic [13:0] pins;
    logic [2:0] onehot;
    if (cyc >= 1 && cyc <= release_edge) begin
      check_value("vga_r", vga_r, 4'h0);
      check_value("vga_g", vga_g, 4'h0);
      check_value("vga_b", vga_b, 4'h0);
      check_value("vga_hs", vga_hs, 1'b1);
      check_value("vga_vs", vga_vs, 1'b1);
      check_value("leds", {led1, led2, led3, led4, led5}, 5'h00);
    end else if (cyc > release_edge) begin
      p = cyc - release_edge - 1;  // pixel shown now
      x = p % h_total;
      y = (p / h_total) % v_total;
      if (x == 0 && y == 0) begin
        exp_pattern = next_pattern(settled_btns, exp_pattern);
        exp_frame_led = ~exp_frame_led;
      end
      pins = expected_pins(x, y, exp_pattern);
      onehot = 3'b001 << exp_pattern;
      check_value("vga_r", vga_r, pins[13:10]);
      check_value("vga_g", vga_g, pins[9:6]);
      check_value("vga_b", vga_b, pins[5:2]);
      check_value("vga_hs", vga_hs, pins[1]);
      check_value("vga_vs", vga_vs, pins[0]);
      check_value("led4", led4, onehot[0]);
      check_value("led3", led3, onehot[1]);
      check_value("led5", led5, onehot[2]);
      check_value("led2", led2, exp_frame_led);
      check_value("led1", led1, (x < h_active && y < v_active));
    end
    if (prev_hs && !vga_hs && first_hs_fall < 0) begin
      first_hs_fall = cyc;
      check_value("first vga_hs fall edge", first_hs_fall, first_hs_edge);
    end
    prev_hs = vga_hs;
  end

  initial begin
    int pick;
    int len;
    int first_btn;
    int second_btn;
    rst = 1'b1;
    drive_btns('0);
    cyc = 0;
    error_count = 0;
    first_hs_fall = -1;
    prev_hs = 1'b1;
    lfsr_state = 32'd92298;
    settled_btns = '0;
    exp_pattern = pattern_bars;
    exp_frame_led = 1'b0;
    repeat (reset_cycles) @(posedge design_clk);
    #1;
    rst = 1'b0;

    take_bits(1, pick);
    first_btn = 1 + pick;  // checker or gradient, bars is already showing
    wait_until_edge(release_edge + 100000);
    press_with_bounce(first_btn);
    wait_cycles(settle_cycles);
    settled_btns = 3'b1 << first_btn;
    wait_until_edge(release_edge + frame_cycles + 50000);
    drive_btns('0);
    wait_cycles(settle_cycles);
    settled_btns = '0;

    // short press held across the frame 2 start, another button than the current one
    take_bits(1, pick);
    take_bits(9, len);
    wait_until_edge(release_edge + 2 * frame_cycles - short_lead);
    drive_btns(3'b1 << ((first_btn + 1 + pick) % 3));
    wait_cycles(short_lead + len);  // still under debounce_cycles
    drive_btns('0);

    take_bits(1, pick);
    second_btn = (first_btn + 1 + pick) % 3;
    wait_until_edge(release_edge + 2 * frame_cycles + 100000);
    press_with_bounce(second_btn);
    wait_cycles(settle_cycles);
    settled_btns = 3'b1 << second_btn;
    wait_until_edge(release_edge + 3 * frame_cycles + 50000);
    drive_btns('0);
    wait_cycles(settle_cycles);
    settled_btns = '0;

    wait_until_edge(end_edge + 1);  // last pixel already compared
    if (error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
hw/board_pkg.sv
hw/video_if.sv
hw/reset_stretcher.sv
hw/button_debouncer.sv
hw/video_timing.sv
hw/pixel_shader.sv
hw/board_top.sv
testbench/board_top_tb.sv

//--- Bender.yml
package:
  name: board_video

sources:
  - hw/board_pkg.sv
  - hw/video_if.sv
  - hw/reset_stretcher.sv
  - hw/button_debouncer.sv
  - hw/video_timing.sv
  - hw/pixel_shader.sv
  - hw/board_top.sv
  - target: test
    files:
      - testbench/board_top_tb.sv
